// File: dv/ising_core_tb.sv
`timescale 1ns/1ps

module ising_core_tb;
    import ising_pkg::*;

    localparam int NUM_TESTS = 5;
    // runs over all tests set the watchdog budget
    localparam int NUM_RUNS  = 12;
    localparam int WDOG_CYC  = NUM_RUNS * (FLIP_DEPTH + 1) * 12 + 500;

    logic       clk_i;
    logic       arst_n_i;
    logic       cfg_we_i;
    cfg_sel_t   cfg_sel_i;
    flip_addr_t cfg_addr_i;
    cfg_data_t  cfg_wdata_i;
    step_cnt_t  step_num_i;
    logic       en_comparison_i;
    logic       start_req_i;
    logic       start_ack_o;
    logic       busy_o;
    spin_t      spin_o;
    energy_t    energy_o;

    // host-side copy of the configuration
    jrow_t   j_m [NUM_SPIN];
    hvec_t   h_m;
    spin_t   mask_m [FLIP_DEPTH];
    spin_t   spin_m;

    spin_t   exp_spin;
    energy_t exp_energy;
    int      runs_started;
    int      checked_runs;
    int      err_cnt;
    int      tests_failed;

    ising_core dut0 (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .cfg_we_i        (cfg_we_i),
        .cfg_sel_i       (cfg_sel_i),
        .cfg_addr_i      (cfg_addr_i),
        .cfg_wdata_i     (cfg_wdata_i),
        .step_num_i      (step_num_i),
        .en_comparison_i (en_comparison_i),
        .start_req_i     (start_req_i),
        .start_ack_o     (start_ack_o),
        .busy_o          (busy_o),
        .spin_o          (spin_o),
        .energy_o        (energy_o)
    );

    always #5 clk_i = ~clk_i;

    // E = -sum_i s_i * (sum_j J_ij * s_j + h_i) with bit 1 as +1
    function automatic energy_t ref_energy(spin_t s);
        int                     e;
        int                     field;
        logic signed [BITJ-1:0] jnib;
        logic signed [BITH-1:0] hnib;
        e = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            hnib  = h_m[i*BITH +: BITH];
            field = hnib;
            for (int j = 0; j < NUM_SPIN; j++) begin
                jnib  = j_m[i][j*BITJ +: BITJ];
                field = field + (s[j] ? int'(jnib) : -int'(jnib));
            end
            e = e + (s[i] ? field : -field);
        end
        return energy_t'(-e);
    endfunction

    task automatic ref_anneal(input spin_t init, input int steps, input bit cmp,
                              output spin_t fin_spin, output energy_t fin_energy);
        spin_t   cur;
        spin_t   cand;
        energy_t e_cur;
        energy_t e_cand;
        cur   = init;
        e_cur = ref_energy(init);
        for (int k = 0; k < steps; k++) begin
            cand   = cur ^ mask_m[k];
            e_cand = ref_energy(cand);
            if (!cmp || e_cand < e_cur) begin
                cur   = cand;
                e_cur = e_cand;
            end
        end
        fin_spin   = cur;
        fin_energy = e_cur;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic cfg_write(input cfg_sel_t sel, input int addr, input cfg_data_t data);
        @(posedge clk_i);
        cfg_we_i    <= 1'b1;
        cfg_sel_i   <= sel;
        cfg_addr_i  <= flip_addr_t'(addr);
        cfg_wdata_i <= data;
    endtask

    task automatic cfg_release();
        @(posedge clk_i);
        cfg_we_i <= 1'b0;
    endtask

    task automatic randomize_config();
        for (int i = 0; i < NUM_SPIN; i++) begin
            j_m[i] = $urandom();
        end
        h_m = $urandom();
        for (int k = 0; k < FLIP_DEPTH; k++) begin
            mask_m[k] = spin_t'($urandom());
        end
        spin_m = spin_t'($urandom());
    endtask

    task automatic load_all();
        for (int i = 0; i < NUM_SPIN; i++) begin
            cfg_write(CFG_SEL_JROW, i, j_m[i]);
        end
        cfg_write(CFG_SEL_HVEC, 0, h_m);
        for (int k = 0; k < FLIP_DEPTH; k++) begin
            cfg_write(CFG_SEL_FLIP, k, cfg_data_t'(mask_m[k]));
        end
        cfg_write(CFG_SEL_SPIN, 0, cfg_data_t'(spin_m));
        cfg_release();
    endtask

    // full four-phase start handshake around one run
    task automatic run_anneal(input int steps, input bit cmp);
        spin_t   fs;
        energy_t fe;
        ref_anneal(spin_m, steps, cmp, fs, fe);
        exp_spin   = fs;
        exp_energy = fe;
        @(posedge clk_i);
        step_num_i      <= step_cnt_t'(steps);
        en_comparison_i <= cmp;
        start_req_i     <= 1'b1;
        runs_started++;
        while (checked_runs != runs_started) begin
            @(negedge clk_i);
        end
        repeat (2) @(negedge clk_i);
        check("start_ack_o", start_ack_o, 1);
        @(posedge clk_i);
        start_req_i <= 1'b0;
        @(posedge clk_i);
        @(negedge clk_i);
        check("start_ack_o", start_ack_o, 0);
        check("busy_o", busy_o, 0);
        spin_m = fs;
    endtask

    // inverted values that must not reach the core while it runs
    task automatic write_while_busy();
        wait (busy_o === 1'b1);
        cfg_write(CFG_SEL_JROW, 0, ~j_m[0]);
        cfg_write(CFG_SEL_JROW, 5, ~j_m[5]);
        cfg_write(CFG_SEL_HVEC, 0, ~h_m);
        cfg_write(CFG_SEL_FLIP, 0, cfg_data_t'(~mask_m[0]));
        cfg_write(CFG_SEL_FLIP, 3, cfg_data_t'(~mask_m[3]));
        cfg_write(CFG_SEL_SPIN, 0, cfg_data_t'(~spin_m));
        cfg_release();
        @(negedge clk_i);
        check("busy_o", busy_o, 1);
    endtask

    task automatic report(input int num, input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, err_cnt - errs_before);
            tests_failed++;
        end
    endtask

    initial begin : ack_checker
        logic ack_prev;
        ack_prev = 1'b0;
        forever begin
            @(negedge clk_i);
            if (start_ack_o === 1'b1 && !ack_prev) begin
                check("spin_o", 32'(spin_o), 32'(exp_spin));
                check("energy_o", 32'(energy_o), 32'(exp_energy));
                checked_runs++;
            end
            ack_prev = (start_ack_o === 1'b1);
        end
    end

    initial begin : watchdog
        repeat (WDOG_CYC) @(posedge clk_i);
        $display("timeout: no finish after %0d cycles, a run is stuck", WDOG_CYC);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : stimulus
        int      base;
        energy_t e0;
        spin_t   xor_all;
        hvec_t   pat;
        void'($urandom(32'h3eee_cd06));
        clk_i           = 1'b0;
        arst_n_i        = 1'b0;
        cfg_we_i        = 1'b0;
        cfg_sel_i       = CFG_SEL_JROW;
        cfg_addr_i      = '0;
        cfg_wdata_i     = '0;
        step_num_i      = '0;
        en_comparison_i = 1'b1;
        start_req_i     = 1'b0;
        runs_started    = 0;
        checked_runs    = 0;
        err_cnt         = 0;
        tests_failed    = 0;
        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check("start_ack_o", start_ack_o, 0);
        check("busy_o", busy_o, 0);

        // zero steps leave only the handshake and initial energy
        base = err_cnt;
        randomize_config();
        load_all();
        run_anneal(0, 1'b1);
        report(1, "zero step handshake", base);

        base = err_cnt;
        for (int r = 0; r < 3; r++) begin
            randomize_config();
            load_all();
            e0 = ref_energy(spin_m);
            run_anneal(16 - r * 5, 1'b1);
            check("energy_o <= initial", 32'(energy_o <= e0), 1);
        end
        report(2, "random anneal with comparison", base);

        base = err_cnt;
        randomize_config();
        load_all();
        for (int r = 0; r < 2; r++) begin
            xor_all = spin_m;
            for (int k = 0; k < 16 - r * 9; k++) begin
                xor_all = xor_all ^ mask_m[k];
            end
            run_anneal(16 - r * 9, 1'b0);
            check("spin_o", 32'(spin_o), 32'(xor_all));
            check("energy_o", 32'(energy_o), 32'(ref_energy(xor_all)));
        end
        report(3, "comparison disabled", base);

        // most negative and most positive weights
        base = err_cnt;
        for (int p = 0; p < 2; p++) begin
            pat = (p == 0) ? 32'h8888_8888 : 32'h7777_7777;
            for (int s = 0; s < 2; s++) begin
                for (int i = 0; i < NUM_SPIN; i++) begin
                    j_m[i] = pat;
                end
                h_m    = pat;
                spin_m = (s == 0) ? '1 : '0;
                load_all();
                run_anneal(0, 1'b1);
            end
        end
        report(4, "extreme weights", base);

        base = err_cnt;
        randomize_config();
        load_all();
        fork
            run_anneal(16, 1'b1);
            write_while_busy();
        join
        run_anneal(9, 1'b1);
        report(5, "config writes while busy", base);

        $display("tests %0d, failed %0d, mismatches %0d", NUM_TESTS, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: ising_core.f
verilog/ising_pkg.sv
verilog/ising_if.sv
verilog/weight_store.sv
verilog/energy_monitor.sv
verilog/flip_manager.sv
verilog/anneal_ctrl.sv
verilog/ising_core.sv
dv/ising_core_tb.sv

// File: verilog/anneal_ctrl.sv
`timescale 1ns/1ps

module anneal_ctrl (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   start_req_i,
    input  ising_pkg::step_cnt_t   step_num_i,
    input  logic                   eval_done_i,
    output logic                   start_ack_o,
    output logic                   busy_o,
    output logic                   cfg_en_o,
    output logic                   init_go_o,
    output logic                   step_go_o,
    output ising_pkg::flip_addr_t  step_idx_o
);
    import ising_pkg::*;

    anneal_state_e state_q;
    logic          req_q;
    logic          init_go_q;
    logic          step_go_q;
    step_cnt_t     step_num_q;
    step_cnt_t     cnt_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            req_q      <= 1'b0;
            init_go_q  <= 1'b0;
            step_go_q  <= 1'b0;
            step_num_q <= '0;
            cnt_q      <= '0;
        end else begin
            req_q     <= start_req_i;
            init_go_q <= 1'b0;
            step_go_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_req_i && !req_q) begin
                        state_q    <= ST_INIT;
                        init_go_q  <= 1'b1;
                        step_num_q <= step_num_i;
                    end
                end
                ST_INIT: begin
                    if (eval_done_i) begin
                        if (step_num_q == '0) begin
                            state_q <= ST_DONE;
                        end else begin
                            state_q   <= ST_STEP;
                            cnt_q     <= '0;
                            step_go_q <= 1'b1;
                        end
                    end
                end
                ST_STEP: begin
                    if (eval_done_i) begin
                        if (step_cnt_t'(cnt_q + 1'b1) == step_num_q) begin
                            state_q <= ST_DONE;
                        end else begin
                            cnt_q     <= cnt_q + 1'b1;
                            step_go_q <= 1'b1;
                        end
                    end
                end
                // ack held until the host drops its request
                ST_DONE: begin
                    if (!start_req_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign start_ack_o = (state_q == ST_DONE);
    assign busy_o      = (state_q != ST_IDLE);
    assign cfg_en_o    = (state_q == ST_IDLE);
    assign init_go_o   = init_go_q;
    assign step_go_o   = step_go_q;
    assign step_idx_o  = flip_addr_t'(cnt_q);

endmodule

// File: verilog/energy_monitor.sv
`timescale 1ns/1ps

module energy_monitor (
    input  logic clk_i,
    input  logic arst_n_i,
    eval_if.eval ev,
    weight_if.rd wr
);
    import ising_pkg::*;

    logic     busy_q;
    logic     run_q;
    grp_idx_t grp_q;
    logic     rd_valid_q;
    logic     rd_last_q;
    grp_idx_t rd_grp_q;
    logic     fin_q;
    spin_t    spin_q;
    energy_t  acc_q;
    energy_t  grp_sum;
    logic     energy_valid_q;
    energy_t  energy_q;
    logic     spin_hs;
    logic     energy_hs;

    // s_i * (sum_j J_ij * s_j + h_i) for one row
    function automatic energy_t row_term(jrow_t row, logic [BITH-1:0] h, spin_t s, logic si);
        energy_t                sum;
        logic signed [BITJ-1:0] jv;
        logic signed [BITH-1:0] hv;
        hv  = h;
        sum = hv;
        for (int j = 0; j < NUM_SPIN; j++) begin
            jv = row[j*BITJ +: BITJ];
            if (s[j]) begin
                sum = sum + jv;
            end else begin
                sum = sum - jv;
            end
        end
        return si ? sum : -sum;
    endfunction

    assign spin_hs   = ev.spin_valid && !busy_q;
    assign energy_hs = energy_valid_q && ev.energy_ready;

    always_comb begin
        grp_sum = '0;
        for (int k = 0; k < PARALLELISM; k++) begin
            grp_sum = grp_sum + row_term(wr.rows[k], wr.hslice[k*BITH +: BITH], spin_q,
                                         spin_q[rd_grp_q * PARALLELISM + k]);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q         <= 1'b0;
            run_q          <= 1'b0;
            grp_q          <= '0;
            rd_valid_q     <= 1'b0;
            rd_last_q      <= 1'b0;
            fin_q          <= 1'b0;
            energy_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= run_q;
            rd_last_q  <= run_q && (grp_q == grp_idx_t'(NUM_ROW_GROUP - 1));
            fin_q      <= rd_valid_q && rd_last_q;
            if (spin_hs) begin
                busy_q <= 1'b1;
                run_q  <= 1'b1;
                grp_q  <= '0;
            end else if (run_q) begin
                // wraps back to zero after the last group
                grp_q <= grp_q + 1'b1;
                if (grp_q == grp_idx_t'(NUM_ROW_GROUP - 1)) begin
                    run_q <= 1'b0;
                end
            end
            if (fin_q) begin
                energy_valid_q <= 1'b1;
            end else if (energy_hs) begin
                energy_valid_q <= 1'b0;
                busy_q         <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        rd_grp_q <= grp_q;
        if (spin_hs) begin
            spin_q <= ev.spin;
            acc_q  <= '0;
        end else if (rd_valid_q) begin
            acc_q <= acc_q + grp_sum;
        end
        if (fin_q) begin
            energy_q <= -acc_q;
        end
    end

    assign ev.spin_ready   = !busy_q;
    assign ev.energy_valid = energy_valid_q;
    assign ev.energy       = energy_q;
    assign wr.ren          = run_q;
    assign wr.grp          = grp_q;

endmodule

// File: verilog/flip_manager.sv
`timescale 1ns/1ps

module flip_manager (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   cfg_we_i,
    input  ising_pkg::cfg_sel_t    cfg_sel_i,
    input  ising_pkg::flip_addr_t  cfg_addr_i,
    input  ising_pkg::cfg_data_t   cfg_wdata_i,
    input  logic                   cfg_en_i,
    input  logic                   en_comparison_i,
    input  logic                   init_go_i,
    input  logic                   step_go_i,
    input  ising_pkg::flip_addr_t  step_idx_i,
    output logic                   eval_done_o,
    output ising_pkg::spin_t       spin_o,
    output ising_pkg::energy_t     energy_o,
    eval_if.src                    ev
);
    import ising_pkg::*;

    spin_t   flip_mem [FLIP_DEPTH];
    spin_t   cand_q;
    spin_t   spin_q;
    energy_t energy_q;
    logic    spin_valid_q;
    logic    wait_q;
    logic    init_q;
    logic    eval_done_q;
    logic    host_we;
    logic    keep;

    assign host_we = cfg_en_i && cfg_we_i;
    // initial vector is always kept, steps only if strictly lower
    assign keep    = init_q || !en_comparison_i || (ev.energy < energy_q);

    always_ff @(posedge clk_i) begin
        if (host_we && cfg_sel_i == CFG_SEL_FLIP) begin
            flip_mem[cfg_addr_i] <= cfg_wdata_i[NUM_SPIN-1:0];
        end
        if (init_go_i) begin
            cand_q <= spin_q;
        end else if (step_go_i) begin
            cand_q <= spin_q ^ flip_mem[step_idx_i];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            spin_valid_q <= 1'b0;
            wait_q       <= 1'b0;
            init_q       <= 1'b0;
            eval_done_q  <= 1'b0;
            spin_q       <= '0;
            energy_q     <= '0;
        end else begin
            eval_done_q <= 1'b0;
            if (init_go_i || step_go_i) begin
                spin_valid_q <= 1'b1;
                init_q       <= init_go_i;
            end else if (spin_valid_q && ev.spin_ready) begin
                spin_valid_q <= 1'b0;
                wait_q       <= 1'b1;
            end
            if (wait_q && ev.energy_valid) begin
                wait_q      <= 1'b0;
                eval_done_q <= 1'b1;
                if (keep) begin
                    spin_q   <= cand_q;
                    energy_q <= ev.energy;
                end
            end else if (host_we && cfg_sel_i == CFG_SEL_SPIN) begin
                spin_q <= cfg_wdata_i[NUM_SPIN-1:0];
            end
        end
    end

    assign ev.spin_valid   = spin_valid_q;
    assign ev.spin         = cand_q;
    assign ev.energy_ready = wait_q;
    assign eval_done_o     = eval_done_q;
    assign spin_o          = spin_q;
    assign energy_o        = energy_q;

endmodule

// File: verilog/ising_core.sv
`timescale 1ns/1ps

module ising_core (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   cfg_we_i,
    input  ising_pkg::cfg_sel_t    cfg_sel_i,
    input  ising_pkg::flip_addr_t  cfg_addr_i,
    input  ising_pkg::cfg_data_t   cfg_wdata_i,
    input  ising_pkg::step_cnt_t   step_num_i,
    input  logic                   en_comparison_i,
    input  logic                   start_req_i,
    output logic                   start_ack_o,
    output logic                   busy_o,
    output ising_pkg::spin_t       spin_o,
    output ising_pkg::energy_t     energy_o
);
    import ising_pkg::*;

    logic       cfg_en;
    logic       ws_cfg_we;
    logic       init_go;
    logic       step_go;
    logic       eval_done;
    flip_addr_t step_idx;

    eval_if   ev ();
    weight_if wr ();

    // host writes only land while idle
    assign ws_cfg_we = cfg_we_i & cfg_en;

    anneal_ctrl u_anneal_ctrl (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .start_req_i (start_req_i),
        .step_num_i  (step_num_i),
        .eval_done_i (eval_done),
        .start_ack_o (start_ack_o),
        .busy_o      (busy_o),
        .cfg_en_o    (cfg_en),
        .init_go_o   (init_go),
        .step_go_o   (step_go),
        .step_idx_o  (step_idx)
    );

    weight_store u_weight_store (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cfg_we_i    (ws_cfg_we),
        .cfg_sel_i   (cfg_sel_i),
        .cfg_addr_i  (spin_idx_t'(cfg_addr_i)),
        .cfg_wdata_i (cfg_wdata_i),
        .wr          (wr.mem)
    );

    energy_monitor u_energy_monitor (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .ev       (ev.eval),
        .wr       (wr.rd)
    );

    flip_manager u_flip_manager (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .cfg_we_i        (cfg_we_i),
        .cfg_sel_i       (cfg_sel_i),
        .cfg_addr_i      (cfg_addr_i),
        .cfg_wdata_i     (cfg_wdata_i),
        .cfg_en_i        (cfg_en),
        .en_comparison_i (en_comparison_i),
        .init_go_i       (init_go),
        .step_go_i       (step_go),
        .step_idx_i      (step_idx),
        .eval_done_o     (eval_done),
        .spin_o          (spin_o),
        .energy_o        (energy_o),
        .ev              (ev.src)
    );

endmodule

// File: verilog/ising_if.sv
`timescale 1ns/1ps

// spin request and energy result channel
interface eval_if;
    import ising_pkg::*;

    logic    spin_valid;
    logic    spin_ready;
    spin_t   spin;
    logic    energy_valid;
    logic    energy_ready;
    energy_t energy;

    modport src (
        output spin_valid, spin, energy_ready,
        input  spin_ready, energy_valid, energy
    );
    modport eval (
        input  spin_valid, spin, energy_ready,
        output spin_ready, energy_valid, energy
    );
endinterface

// one group of J rows per read, data one cycle after ren
interface weight_if;
    import ising_pkg::*;

    logic                        ren;
    grp_idx_t                    grp;
    jrow_t [PARALLELISM-1:0]     rows;
    logic [PARALLELISM*BITH-1:0] hslice;

    modport rd  (output ren, grp, input  rows, hslice);
    modport mem (input  ren, grp, output rows, hslice);
endinterface

// File: verilog/ising_pkg.sv
package ising_pkg;

    localparam int NUM_SPIN      = 8;
    localparam int BITJ          = 4;
    localparam int BITH          = 4;
    localparam int PARALLELISM   = 2;
    localparam int NUM_ROW_GROUP = NUM_SPIN / PARALLELISM;
    localparam int FLIP_DEPTH    = 16;
    localparam int ENERGY_BIT    = 16;
    localparam int CFG_WIDTH     = 32;

    typedef logic [NUM_SPIN-1:0]                 spin_t;
    typedef logic [NUM_SPIN*BITJ-1:0]            jrow_t;
    typedef logic [NUM_SPIN*BITH-1:0]            hvec_t;
    typedef logic signed [ENERGY_BIT-1:0]        energy_t;
    typedef logic [$clog2(NUM_SPIN)-1:0]         spin_idx_t;
    typedef logic [$clog2(NUM_ROW_GROUP)-1:0]    grp_idx_t;
    typedef logic [$clog2(FLIP_DEPTH)-1:0]       flip_addr_t;
    typedef logic [$clog2(FLIP_DEPTH+1)-1:0]     step_cnt_t;
    typedef logic [1:0]                          cfg_sel_t;
    typedef logic [CFG_WIDTH-1:0]                cfg_data_t;

    // host configuration targets
    localparam cfg_sel_t CFG_SEL_JROW = 2'd0;
    localparam cfg_sel_t CFG_SEL_HVEC = 2'd1;
    localparam cfg_sel_t CFG_SEL_FLIP = 2'd2;
    localparam cfg_sel_t CFG_SEL_SPIN = 2'd3;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_INIT,
        ST_STEP,
        ST_DONE
    } anneal_state_e;

endpackage

// File: verilog/weight_store.sv
`timescale 1ns/1ps

module weight_store (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  cfg_we_i,
    input  ising_pkg::cfg_sel_t   cfg_sel_i,
    input  ising_pkg::spin_idx_t  cfg_addr_i,
    input  ising_pkg::cfg_data_t  cfg_wdata_i,
    weight_if.mem                 wr
);
    import ising_pkg::*;

    jrow_t                       j_mem [NUM_SPIN];
    hvec_t                       h_vec;
    jrow_t [PARALLELISM-1:0]     rows_q;
    logic [PARALLELISM*BITH-1:0] hslice_q;

    // host writes, row i holds J_ij at bits j*BITJ
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_SPIN; i++) begin
                j_mem[i] <= '0;
            end
            h_vec <= '0;
        end else if (cfg_we_i) begin
            if (cfg_sel_i == CFG_SEL_JROW) begin
                j_mem[cfg_addr_i] <= cfg_wdata_i;
            end else if (cfg_sel_i == CFG_SEL_HVEC) begin
                h_vec <= cfg_wdata_i;
            end
        end
    end

    // registered group read
    always_ff @(posedge clk_i) begin
        if (wr.ren) begin
            for (int k = 0; k < PARALLELISM; k++) begin
                rows_q[k] <= j_mem[wr.grp * PARALLELISM + k];
            end
            hslice_q <= h_vec[wr.grp * PARALLELISM * BITH +: PARALLELISM * BITH];
        end
    end

    assign wr.rows   = rows_q;
    assign wr.hslice = hslice_q;

endmodule
